// ==== verilog/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	////////////////////////////////////////////////////////////
	// Widths and memory sizes
	////////////////////////////////////////////////////////////
	localparam int XLEN       = 32;
	localparam int REG_AW     = 5;
	localparam int IMEM_DEPTH = 64;
	localparam int DMEM_DEPTH = 64;
	// Word addresses into each memory
	localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
	localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

	typedef logic [XLEN-1:0]   word_t;
	typedef logic [REG_AW-1:0] reg_addr_t;

	////////////////////////////////////////////////////////////
	// Instruction fields
	////////////////////////////////////////////////////////////
	// Primary opcode, bits 31:26
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_ADDI  = 6'h08,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	// R-type function field, bits 5:0
	typedef enum logic [5:0] {
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_op_e;

	// Operand source chosen by the hazard unit
	typedef enum logic [1:0] {
		FWD_NONE = 2'b00,
		FWD_WB   = 2'b01,
		FWD_MEM  = 2'b10
	} fwd_sel_e;

	////////////////////////////////////////////////////////////
	// Pipeline registers
	////////////////////////////////////////////////////////////
	typedef struct packed {
		word_t instr;
		logic  valid;
	} if_id_t;

	typedef struct packed {
		logic      reg_write;
		logic      mem_to_reg;
		logic      mem_write;
		logic      alu_src;
		logic      reg_dst;
		alu_op_e   alu_op;
		word_t     reg_a;
		word_t     reg_b;
		word_t     imm;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
	} id_ex_t;

	typedef struct packed {
		logic      reg_write;
		logic      mem_to_reg;
		logic      mem_write;
		word_t     alu_result;
		word_t     store_data;
		reg_addr_t dest;
	} ex_mem_t;

	typedef struct packed {
		logic      reg_write;
		logic      mem_to_reg;
		word_t     read_data;
		word_t     alu_result;
		reg_addr_t dest;
	} mem_wb_t;

endpackage

`default_nettype wire

// ==== verilog/hazard_if.sv ====
`default_nettype none

interface hazard_if import cpu_pkg::*; ();

	// Decode stage sources
	reg_addr_t rs_d;
	reg_addr_t rt_d;
	// Execute stage, ID/EX view
	reg_addr_t rs_e;
	reg_addr_t rt_e;
	logic      mem_to_reg_e;
	reg_addr_t dest_e;
	// Execute stage, EX/MEM view
	logic      reg_write_m;
	reg_addr_t dest_m;
	// MEM/WB view
	logic      reg_write_w;
	reg_addr_t dest_w;
	// Hazard unit results
	fwd_sel_e  fwd_a;
	fwd_sel_e  fwd_b;
	logic      stall;
	logic      bubble;

	modport hazard (
		input  rs_d, rt_d, rs_e, rt_e, mem_to_reg_e, dest_e,
		input  reg_write_m, dest_m, reg_write_w, dest_w,
		output fwd_a, fwd_b, stall, bubble
	);

	modport decode (output rs_d, rt_d, input bubble);

	modport execute (
		output rs_e, rt_e, mem_to_reg_e, dest_e, reg_write_m, dest_m,
		input  fwd_a, fwd_b
	);

	modport memory (output reg_write_w, dest_w);

endinterface

`default_nettype wire

// ==== verilog/fetch_stage.sv ====
`default_nettype none

module fetch_stage import cpu_pkg::*; (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               run,
	input  wire logic               stall,
	input  wire logic               imem_we,
	input  wire logic [IMEM_AW-1:0] imem_addr,
	input  wire word_t              imem_wdata,
	output if_id_t                  if_id
);

	// Byte program counter
	word_t pc;
	word_t imem [IMEM_DEPTH];
	word_t instr;

	// Load port, works with run low
	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_wdata;
		end
	end

	// Word address, byte offset dropped
	assign instr = imem[pc[IMEM_AW+1:2]];

	////////////////////////////////////////////////////////////
	// PC and IF/ID register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc          <= '0;
			if_id.valid <= 1'b0;
		end else if (run && !stall) begin
			pc          <= pc + 32'd4;
			if_id.instr <= instr;
			if_id.valid <= 1'b1;
		end
		// Load-use stall holds both
	end

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`default_nettype none

module decode_stage import cpu_pkg::*; (
	input  wire logic      clk,
	input  wire logic      rst_n,
	input  wire logic      run,
	input  wire if_id_t    if_id,
	input  wire logic      wb_valid,
	input  wire reg_addr_t wb_addr,
	input  wire word_t     wb_data,
	hazard_if.decode       hz,
	output id_ex_t         id_ex
);

	word_t     regs [2**REG_AW];
	opcode_e   op;
	funct_e    fn;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	reg_addr_t dest;
	id_ex_t    nxt;

	// Instruction fields
	assign op = opcode_e'(if_id.instr[31:26]);
	assign fn = funct_e'(if_id.instr[5:0]);
	assign rs = if_id.instr[25:21];
	assign rt = if_id.instr[20:16];
	assign rd = if_id.instr[15:11];

	assign hz.rs_d = rs;
	assign hz.rt_d = rt;

	// r0 reads zero, same-cycle write-back wins over the array
	function automatic word_t read_reg(reg_addr_t a);
		if (a == '0) begin
			return '0;
		end else if (wb_valid && wb_addr == a) begin
			return wb_data;
		end
		return regs[a];
	endfunction

	////////////////////////////////////////////////////////////
	// Control decode
	////////////////////////////////////////////////////////////
	always_comb begin
		nxt       = '0;
		nxt.alu_op = ALU_ADD;
		nxt.reg_a = read_reg(rs);
		nxt.reg_b = read_reg(rt);
		nxt.imm   = {{(XLEN-16){if_id.instr[15]}}, if_id.instr[15:0]};
		nxt.rs    = rs;
		nxt.rt    = rt;
		nxt.rd    = rd;
		case (op)
			OP_RTYPE: begin
				nxt.reg_dst   = 1'b1;
				nxt.reg_write = 1'b1;
				case (fn)
					FN_ADD:  nxt.alu_op = ALU_ADD;
					FN_SUB:  nxt.alu_op = ALU_SUB;
					FN_AND:  nxt.alu_op = ALU_AND;
					FN_OR:   nxt.alu_op = ALU_OR;
					FN_SLT:  nxt.alu_op = ALU_SLT;
					// unknown funct acts as a nop
					default: nxt.reg_write = 1'b0;
				endcase
			end
			OP_ADDI: begin
				nxt.reg_write = 1'b1;
				nxt.alu_src   = 1'b1;
			end
			OP_LW: begin
				nxt.reg_write  = 1'b1;
				nxt.mem_to_reg = 1'b1;
				nxt.alu_src    = 1'b1;
			end
			OP_SW: begin
				nxt.mem_write = 1'b1;
				nxt.alu_src   = 1'b1;
			end
			default: ;
		endcase
		// Writes to r0 are dropped here and nowhere else
		dest = nxt.reg_dst ? rd : rt;
		if (dest == '0) begin
			nxt.reg_write  = 1'b0;
			nxt.mem_to_reg = 1'b0;
		end
		// Empty IF/ID slot
		if (!if_id.valid) begin
			nxt.reg_write  = 1'b0;
			nxt.mem_to_reg = 1'b0;
			nxt.mem_write  = 1'b0;
		end
	end

	// Register file, wb_valid is only high on run cycles
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**REG_AW; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_valid) begin
			regs[wb_addr] <= wb_data;
		end
	end

	////////////////////////////////////////////////////////////
	// ID/EX register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_ex.reg_write  <= 1'b0;
			id_ex.mem_to_reg <= 1'b0;
			id_ex.mem_write  <= 1'b0;
		end else if (run) begin
			// Bubble on load-use
			id_ex <= hz.bubble ? id_ex_t'('0) : nxt;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/execute_stage.sv ====
`default_nettype none

module execute_stage import cpu_pkg::*; (
	input  wire logic   clk,
	input  wire logic   rst_n,
	input  wire logic   run,
	input  wire id_ex_t id_ex,
	input  wire word_t  wb_data,
	hazard_if.execute   hz,
	output ex_mem_t     ex_mem
);

	word_t     op_a;
	word_t     store_data;
	word_t     op_b;
	word_t     result;
	reg_addr_t dest;

	// Operand source from the EX/MEM result or the write-back value
	function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val);
		case (sel)
			FWD_MEM: return ex_mem.alu_result;
			FWD_WB:  return wb_data;
			default: return reg_val;
		endcase
	endfunction

	always_comb begin
		op_a       = fwd_mux(hz.fwd_a, id_ex.reg_a);
		store_data = fwd_mux(hz.fwd_b, id_ex.reg_b);
	end

	// Immediate for addi, lw, sw
	assign op_b       = id_ex.alu_src ? id_ex.imm : store_data;

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////
	always_comb begin
		case (id_ex.alu_op)
			ALU_SUB: result = op_a - op_b;
			ALU_AND: result = op_a & op_b;
			ALU_OR:  result = op_a | op_b;
			// Signed compare
			ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			default: result = op_a + op_b;
		endcase
	end

	// rd for R-type and rt otherwise
	assign dest = id_ex.reg_dst ? id_ex.rd : id_ex.rt;

	// Hazard unit view
	assign hz.rs_e         = id_ex.rs;
	assign hz.rt_e         = id_ex.rt;
	assign hz.mem_to_reg_e = id_ex.mem_to_reg;
	assign hz.dest_e       = dest;
	assign hz.reg_write_m  = ex_mem.reg_write;
	assign hz.dest_m       = ex_mem.dest;

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem.reg_write  <= 1'b0;
			ex_mem.mem_to_reg <= 1'b0;
			ex_mem.mem_write  <= 1'b0;
		end else if (run) begin
			ex_mem.reg_write  <= id_ex.reg_write;
			ex_mem.mem_to_reg <= id_ex.mem_to_reg;
			ex_mem.mem_write  <= id_ex.mem_write;
			ex_mem.alu_result <= result;
			ex_mem.store_data <= store_data;
			ex_mem.dest       <= dest;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/memory_stage.sv ====
`default_nettype none

module memory_stage import cpu_pkg::*; (
	input  wire logic    clk,
	input  wire logic    rst_n,
	input  wire logic    run,
	input  wire ex_mem_t ex_mem,
	hazard_if.memory     hz,
	output logic         wb_valid,
	output reg_addr_t    wb_addr,
	output word_t        wb_data
);

	word_t              dmem [DMEM_DEPTH];
	logic [DMEM_AW-1:0] dmem_addr;
	word_t              read_data;
	mem_wb_t            mem_wb;

	// Word address from the ALU result
	assign dmem_addr = ex_mem.alu_result[DMEM_AW+1:2];
	assign read_data = dmem[dmem_addr];

	always_ff @(posedge clk) begin
		if (run && ex_mem.mem_write) begin
			dmem[dmem_addr] <= ex_mem.store_data;
		end
	end

	////////////////////////////////////////////////////////////
	// MEM/WB register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_wb.reg_write  <= 1'b0;
			mem_wb.mem_to_reg <= 1'b0;
		end else if (run) begin
			mem_wb.reg_write  <= ex_mem.reg_write;
			mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
			mem_wb.read_data  <= read_data;
			mem_wb.alu_result <= ex_mem.alu_result;
			mem_wb.dest       <= ex_mem.dest;
		end
	end

	// Write-back select, one event per run cycle
	assign wb_valid = mem_wb.reg_write && run;
	assign wb_addr  = mem_wb.dest;
	assign wb_data  = mem_wb.mem_to_reg ? mem_wb.read_data : mem_wb.alu_result;

	assign hz.reg_write_w = mem_wb.reg_write;
	assign hz.dest_w      = mem_wb.dest;

endmodule

`default_nettype wire

// ==== verilog/hazard_unit.sv ====
`default_nettype none

module hazard_unit import cpu_pkg::*; (
	hazard_if.hazard hz
);

	logic load_use;

	////////////////////////////////////////////////////////////
	// Forwarding into EX
	////////////////////////////////////////////////////////////
	// Newest producer first
	function automatic fwd_sel_e pick_src(reg_addr_t src);
		if (hz.reg_write_m && hz.dest_m == src) begin
			return FWD_MEM;
		end else if (hz.reg_write_w && hz.dest_w == src) begin
			return FWD_WB;
		end
		return FWD_NONE;
	endfunction

	// r0 never matches since reg_write is already clear for it
	always_comb begin
		hz.fwd_a = pick_src(hz.rs_e);
		hz.fwd_b = pick_src(hz.rt_e);
	end

	////////////////////////////////////////////////////////////
	// Load-use
	////////////////////////////////////////////////////////////
	// Load in EX feeding the instruction in ID
	assign load_use = hz.mem_to_reg_e &&
		(hz.dest_e == hz.rs_d || hz.dest_e == hz.rt_d);

	// Hold IF and ID and insert one EX bubble
	assign hz.stall  = load_use;
	assign hz.bubble = load_use;

endmodule

`default_nettype wire

// ==== verilog/pipeline_top.sv ====
`default_nettype none

module pipeline_top import cpu_pkg::*; (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               run,
	// Instruction memory load port
	input  wire logic               imem_we,
	input  wire logic [IMEM_AW-1:0] imem_addr,
	input  wire word_t              imem_wdata,
	// Write-back trace
	output logic                    wb_valid,
	output reg_addr_t               wb_addr,
	output word_t                   wb_data
);

	////////////////////////////////////////////////////////////
	// Stage-to-stage links
	////////////////////////////////////////////////////////////
	if_id_t  if_id;
	id_ex_t  id_ex;
	ex_mem_t ex_mem;

	// Hazard detection and forwarding bundle
	hazard_if hz ();

	hazard_unit i_hazard_unit (
		.hz (hz.hazard)
	);

	// IF
	fetch_stage i_fetch_stage (
		.clk        (clk),
		.rst_n      (rst_n),
		.run        (run),
		.stall      (hz.stall),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.if_id      (if_id)
	);

	// ID, register file written from WB
	decode_stage i_decode_stage (
		.clk      (clk),
		.rst_n    (rst_n),
		.run      (run),
		.if_id    (if_id),
		.wb_valid (wb_valid),
		.wb_addr  (wb_addr),
		.wb_data  (wb_data),
		.hz       (hz.decode),
		.id_ex    (id_ex)
	);

	// EX
	execute_stage i_execute_stage (
		.clk     (clk),
		.rst_n   (rst_n),
		.run     (run),
		.id_ex   (id_ex),
		.wb_data (wb_data),
		.hz      (hz.execute),
		.ex_mem  (ex_mem)
	);

	// MEM and WB
	memory_stage i_memory_stage (
		.clk      (clk),
		.rst_n    (rst_n),
		.run      (run),
		.ex_mem   (ex_mem),
		.hz       (hz.memory),
		.wb_valid (wb_valid),
		.wb_addr  (wb_addr),
		.wb_data  (wb_data)
	);

endmodule

`default_nettype wire

// ==== dv/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Each row: {test number [39:32], instruction word [31:0]}
// Words sit in program order, unlisted words load as zero (a nop)
localparam int NUM_TESTS = 6;
localparam int NUM_ROWS  = 60;

localparam logic [39:0] PROG_TABLE [NUM_ROWS] = '{
	// Test 1, independent addi and a nop
	{8'd1, 32'h20010005},  // addi r1, r0, 5
	{8'd1, 32'h2002FFFD},  // addi r2, r0, -3
	{8'd1, 32'h00000000},  // nop
	{8'd1, 32'h20037FFF},  // addi r3, r0, 0x7fff
	// Test 2, back-to-back chain over all ALU ops
	{8'd2, 32'h2001000A},  // addi r1, r0, 10
	{8'd2, 32'h20220003},  // addi r2, r1, 3
	{8'd2, 32'h00411822},  // sub  r3, r2, r1
	{8'd2, 32'h00622024},  // and  r4, r3, r2
	{8'd2, 32'h00822825},  // or   r5, r4, r2
	{8'd2, 32'h2006FFF8},  // addi r6, r0, -8
	{8'd2, 32'h00C5382A},  // slt  r7, r6, r5
	{8'd2, 32'h00A6402A},  // slt  r8, r5, r6
	{8'd2, 32'h00E64820},  // add  r9, r7, r6
	{8'd2, 32'h00095022},  // sub  r10, r0, r9
	{8'd2, 32'h200C0001},  // addi r12, r0, 1
	{8'd2, 32'h00000000},  // nop
	{8'd2, 32'h00000000},  // nop
	{8'd2, 32'h018C6820},  // add  r13, r12, r12
	// Test 3, store then load back
	{8'd3, 32'h20010040},  // addi r1, r0, 0x40
	{8'd3, 32'h20021234},  // addi r2, r0, 0x1234
	{8'd3, 32'hAC220004},  // sw   r2, 4(r1)
	{8'd3, 32'h20030007},  // addi r3, r0, 7
	{8'd3, 32'h20040009},  // addi r4, r0, 9
	{8'd3, 32'h8C250004},  // lw   r5, 4(r1)
	{8'd3, 32'hAC230000},  // sw   r3, 0(r1)
	{8'd3, 32'h00000000},  // nop
	{8'd3, 32'h8C260000},  // lw   r6, 0(r1)
	{8'd3, 32'h00A63820},  // add  r7, r5, r6
	// Test 4, load followed by its user
	{8'd4, 32'h20010020},  // addi r1, r0, 0x20
	{8'd4, 32'h2002FF9C},  // addi r2, r0, -100
	{8'd4, 32'hAC220000},  // sw   r2, 0(r1)
	{8'd4, 32'h8C230000},  // lw   r3, 0(r1)
	{8'd4, 32'h00632020},  // add  r4, r3, r3
	{8'd4, 32'h8C250000},  // lw   r5, 0(r1)
	{8'd4, 32'h00253022},  // sub  r6, r1, r5
	{8'd4, 32'h20C70001},  // addi r7, r6, 1
	{8'd4, 32'h8C280000},  // lw   r8, 0(r1)
	{8'd4, 32'hAC280004},  // sw   r8, 4(r1)
	{8'd4, 32'h8C290004},  // lw   r9, 4(r1)
	{8'd4, 32'h01205025},  // or   r10, r9, r0
	// Test 5, writes aimed at r0
	{8'd5, 32'h20000037},  // addi r0, r0, 55
	{8'd5, 32'h20010004},  // addi r1, r0, 4
	{8'd5, 32'h00210020},  // add  r0, r1, r1
	{8'd5, 32'h00011020},  // add  r2, r0, r1
	{8'd5, 32'h00011822},  // sub  r3, r0, r1
	{8'd5, 32'hAC210000},  // sw   r1, 0(r1)
	{8'd5, 32'h8C200000},  // lw   r0, 0(r1)
	{8'd5, 32'h00002020},  // add  r4, r0, r0
	{8'd5, 32'h00012825},  // or   r5, r0, r1
	// Test 6, mixed program under random run drops
	{8'd6, 32'h20010030},  // addi r1, r0, 0x30
	{8'd6, 32'h2022FFFB},  // addi r2, r1, -5
	{8'd6, 32'hAC220000},  // sw   r2, 0(r1)
	{8'd6, 32'h8C230000},  // lw   r3, 0(r1)
	{8'd6, 32'h00622020},  // add  r4, r3, r2
	{8'd6, 32'h0044282A},  // slt  r5, r2, r4
	{8'd6, 32'h00A43022},  // sub  r6, r5, r4
	{8'd6, 32'h00C23824},  // and  r7, r6, r2
	{8'd6, 32'h20E80064},  // addi r8, r7, 100
	{8'd6, 32'h8C290000},  // lw   r9, 0(r1)
	{8'd6, 32'h01285025}   // or   r10, r9, r8
};

// Expected number of write-back events per test
localparam int EXP_WRITES [NUM_TESTS] = '{3, 12, 7, 10, 5, 10};

// Tests that drop run at random cycles
localparam bit RUN_JITTER [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

`endif

// ==== dv/tb_pipeline.sv ====
`default_nettype none

module tb_pipeline import cpu_pkg::*; ();

	`include "tb_program.svh"

	localparam int          RESET_CYCLES = 16;
	localparam int          IDLE_CYCLES  = 8;
	localparam int          DRAIN_CYCLES = 8;
	localparam logic [31:0] SEED         = 32'hf5759196;
	// 20 per row and 64 per test, plus memory load and reset of each test
	localparam int          CYCLE_LIMIT  = 20 * NUM_ROWS + 64 * NUM_TESTS +
		(IMEM_DEPTH + RESET_CYCLES + IDLE_CYCLES + 4) * NUM_TESTS;

	logic               clk;
	logic               rst_n;
	logic               run;
	logic               imem_we;
	logic [IMEM_AW-1:0] imem_addr;
	word_t              imem_wdata;
	logic               wb_valid;
	reg_addr_t          wb_addr;
	word_t              wb_data;

	// Current program and its write-backs in program order
	word_t     prog [$];
	reg_addr_t exp_addr [$];
	word_t     exp_data [$];

	int cur_test;
	int got;
	int test_errors;
	int total_errors;
	int passed;
	int failed;
	int cycle_count;

	pipeline_top i_pipeline_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.run        (run),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.wb_valid   (wb_valid),
		.wb_addr    (wb_addr),
		.wb_data    (wb_data)
	);

	always #2 clk = ~clk;

	// Watchdog
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("Timeout in test %0d after %0d cycles", cur_test, CYCLE_LIMIT);
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic record_error();
		test_errors++;
		total_errors++;
	endtask

	////////////////////////////////////////////////////////////
	// Program load and reset
	////////////////////////////////////////////////////////////
	task automatic load_program(input int test);
		prog.delete();
		for (int r = 0; r < NUM_ROWS; r++) begin
			if (int'(PROG_TABLE[r][39:32]) == test) begin
				prog.push_back(PROG_TABLE[r][31:0]);
			end
		end
		// Whole memory, zero words are nops
		for (int a = 0; a < IMEM_DEPTH; a++) begin
			@(negedge clk);
			imem_we    = 1'b1;
			imem_addr  = IMEM_AW'(a);
			imem_wdata = (a < prog.size()) ? prog[a] : '0;
		end
		@(negedge clk);
		imem_we = 1'b0;
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
	endtask

	////////////////////////////////////////////////////////////
	// Reference model, one instruction at a time
	////////////////////////////////////////////////////////////
	task automatic build_expected();
		word_t     rf [32];
		word_t     dm [DMEM_DEPTH];
		word_t     w;
		word_t     a;
		word_t     b;
		word_t     imm;
		word_t     res;
		reg_addr_t dst;
		bit        wr;
		exp_addr.delete();
		exp_data.delete();
		foreach (rf[i]) rf[i] = '0;
		foreach (dm[i]) dm[i] = '0;
		foreach (prog[i]) begin
			w   = prog[i];
			a   = rf[w[25:21]];
			b   = rf[w[20:16]];
			imm = {{16{w[15]}}, w[15:0]};
			wr  = 1'b0;
			res = '0;
			dst = w[20:16];
			case (w[31:26])
				// R-type, destination in rd
				6'h00: begin
					dst = w[15:11];
					wr  = 1'b1;
					case (w[5:0])
						6'h20:   res = a + b;
						6'h22:   res = a - b;
						6'h24:   res = a & b;
						6'h25:   res = a | b;
						6'h2a:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: wr = 1'b0;
					endcase
				end
				6'h08: begin
					res = a + imm;
					wr  = 1'b1;
				end
				6'h23: begin
					res = dm[(a + imm) >> 2];
					wr  = 1'b1;
				end
				6'h2b: dm[(a + imm) >> 2] = b;
				default: ;
			endcase
			// r0 keeps zero and produces no event
			if (wr && dst != '0) begin
				rf[dst] = res;
				exp_addr.push_back(dst);
				exp_data.push_back(res);
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// One clock, with write-back check
	////////////////////////////////////////////////////////////
	task automatic step_cycle(input bit run_val);
		@(negedge clk);
		run = run_val;
		@(posedge clk);
		if (wb_valid && !run_val) begin
			$display("[FAIL] t=%0t wb_valid: got 1, expected 0", $time);
			record_error();
		end else if (wb_valid && got >= exp_addr.size()) begin
			$display("Test %0d: unexpected extra write-back to r%0d, value 0x%08h",
				cur_test, wb_addr, wb_data);
			record_error();
		end else if (wb_valid) begin
			if (wb_addr !== exp_addr[got]) begin
				$display("[FAIL] t=%0t wb_addr: got %0d, expected %0d",
					$time, wb_addr, exp_addr[got]);
				record_error();
			end
			if (wb_data !== exp_data[got]) begin
				$display("[FAIL] t=%0t wb_data: got 0x%08h, expected 0x%08h",
					$time, wb_data, exp_data[got]);
				record_error();
			end
			got++;
		end
	endtask

	task automatic run_program();
		int run_cycles;
		int max_run;
		bit jitter;
		bit run_val;
		run_cycles = 0;
		max_run    = 2 * prog.size() + 16;
		jitter     = RUN_JITTER[cur_test - 1];
		got        = 0;
		// Until every expected write-back has arrived
		while (got < exp_addr.size() && run_cycles < max_run) begin
			run_val = jitter ? (($urandom % 4) != 0) : 1'b1;
			step_cycle(run_val);
			if (run_val) begin
				run_cycles++;
			end
		end
		if (got < exp_addr.size()) begin
			$display("Test %0d: only %0d of %0d expected write-backs arrived",
				cur_test, got, exp_addr.size());
			record_error();
		end
		// Trailing nops, nothing more may retire
		repeat (DRAIN_CYCLES) step_cycle(1'b1);
		@(negedge clk);
		run = 1'b0;
	endtask

	initial begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		run          = 1'b0;
		imem_we      = 1'b0;
		imem_addr    = '0;
		imem_wdata   = '0;
		cur_test     = 0;
		got          = 0;
		test_errors  = 0;
		total_errors = 0;
		passed       = 0;
		failed       = 0;
		cycle_count  = 0;
		void'($urandom(SEED));
		for (int t = 1; t <= NUM_TESTS; t++) begin
			cur_test    = t;
			test_errors = 0;
			load_program(t);
			apply_reset();
			build_expected();
			if (exp_addr.size() != EXP_WRITES[t - 1]) begin
				$display("Test %0d: model predicts %0d write-backs but the table lists %0d",
					t, exp_addr.size(), EXP_WRITES[t - 1]);
				record_error();
			end
			// Out of reset with run low
			repeat (IDLE_CYCLES) step_cycle(1'b0);
			run_program();
			if (test_errors == 0) begin
				passed++;
				$display("Test %0d passed, %0d write-backs checked", t, got);
			end else begin
				failed++;
				$display("Test %0d failed with %0d errors", t, test_errors);
			end
		end
		$display("Tests passed: %0d, failed: %0d", passed, failed);
		if (total_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+dv
verilog/cpu_pkg.sv
verilog/hazard_if.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/hazard_unit.sv
verilog/pipeline_top.sv
dv/tb_pipeline.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log
PASS_MSG="Finished with no errors"

verilator --binary --timing -Wno-fatal \
	--top-module tb_pipeline \
	--Mdir "$OBJ_DIR" -o sim_pipeline \
	-f files.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ_DIR/sim_pipeline" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "$PASS_MSG" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
